// File: rtl/pongPkg.sv
`default_nettype none

package pongPkg;

    // board geometry
    localparam int BoardSize = 8;

    typedef logic [2:0] column_t;
    typedef logic [7:0] rowMask_t;

    localparam column_t PaddleWidth = 3'd3;
    localparam column_t PaddleMax = 3'd5;
    localparam column_t PaddleHome = 3'd3;
    localparam column_t ServeColumn = 3'd4;

    localparam logic [2:0] RedRow = 3'd7;
    localparam logic [2:0] BlueRow = 3'd0;
    localparam logic [2:0] RedHitRow = 3'd6;
    localparam logic [2:0] BlueHitRow = 3'd1;

    // tick periods in clock cycles, powers of two
    localparam int ScanPeriod = 4;
    localparam int PaddlePeriod = 16;
    localparam int BallPeriod = 32;
    localparam int SecondPeriod = 2048;
    localparam int TickPeriods [4] = '{ScanPeriod, PaddlePeriod, BallPeriod, SecondPeriod};

    // sideways ball step
    localparam logic [1:0] StepNone = 2'd0;
    localparam logic [1:0] StepLeft = 2'd1;
    localparam logic [1:0] StepRight = 2'd2;

    typedef logic [4:0] score_t;
    localparam score_t ScoreFull = 5'b11111;

    typedef logic [3:0] digit_t;
    localparam digit_t CountStart = 4'd9;

    // active low, bit 0 is segment a
    typedef logic [6:0] segments_t;

    // active-low colour rows
    localparam rowMask_t RowsOff = 8'hff;
    localparam rowMask_t RowsOn = 8'h00;

    typedef enum logic [1:0] {playing, redWins, blueWins, draw} result_t;

    typedef struct packed {
        logic left;
        logic right;
    } buttons_t;

    typedef struct packed {
        column_t column;
        rowMask_t red;
        rowMask_t green;
        rowMask_t blue;
    } ledFrame_t;

endpackage

`default_nettype wire

// File: rtl/tickGenerator.sv
`default_nettype none

module tickGenerator
(
    input  wire  CLk,
    input  wire  Clear,
    output logic scanTick,
    output logic paddleTick,
    output logic ballTick,
    output logic secondTick
);

    logic [3:0] ticks;

    // one free-running counter per period, pulse on the all-ones count
    for (genvar i = 0; i < 4; i++)
    begin : tickCounter
        logic [$clog2(pongPkg::TickPeriods[i])-1:0] count;
        logic tick;

        always_ff @(posedge CLk or posedge Clear)
        begin
            if (Clear)
            begin
                count <= '0;
                tick <= 1'b0;
            end
            else
            begin
                count <= count + 1'b1;
                tick <= &count;
            end
        end

        assign ticks[i] = tick;
    end

    assign {secondTick, ballTick, paddleTick, scanTick} = ticks;

endmodule

`default_nettype wire

// File: rtl/paddleControl.sv
`default_nettype none

module paddleControl
(
    input  wire               CLk,
    input  wire               Clear,
    input  wire               paddleTick,
    input  wire               pointScored,
    input  pongPkg::buttons_t buttons,
    output pongPkg::column_t  position
);

    always_ff @(posedge CLk or posedge Clear)
    begin
        if (Clear)
            position <= pongPkg::PaddleHome;
        else if (pointScored)
            position <= pongPkg::PaddleHome;
        else if (paddleTick)
        begin
            // both buttons together cancel out
            if (buttons.right && !buttons.left && position != pongPkg::PaddleMax)
                position <= position + 3'd1;
            else if (buttons.left && !buttons.right && position != 3'd0)
                position <= position - 3'd1;
        end
    end

    paddleOnBoard: assert property (@(posedge CLk) disable iff (Clear)
        position <= pongPkg::PaddleMax);

endmodule

`default_nettype wire

// File: rtl/ballEngine.sv
`default_nettype none

module ballEngine
(
    input  wire               CLk,
    input  wire               Clear,
    input  wire               ballTick,
    input  pongPkg::column_t  redPaddle,
    input  pongPkg::column_t  bluePaddle,
    input  pongPkg::result_t  result,
    output pongPkg::column_t  ballColumn,
    output logic [2:0]        ballRow,
    output pongPkg::score_t   redScore,
    output pongPkg::score_t   blueScore,
    output logic              pointScored
);

    logic towardRed;
    logic [1:0] step;
    pongPkg::column_t paddle;
    pongPkg::column_t offset;
    logic [2:0] hitRow;
    logic hit;
    logic [1:0] hitStep;

    // paddle and hit row of the side the ball is heading for
    always_comb
    begin
        paddle = towardRed ? redPaddle : bluePaddle;
        hitRow = towardRed ? pongPkg::RedHitRow : pongPkg::BlueHitRow;
        offset = ballColumn - paddle;
        hit = (ballColumn >= paddle) && (offset < pongPkg::PaddleWidth);
        case (offset)
            3'd0: hitStep = pongPkg::StepLeft;
            3'd1: hitStep = pongPkg::StepNone;
            default: hitStep = pongPkg::StepRight;
        endcase
    end

    always_ff @(posedge CLk or posedge Clear)
    begin
        if (Clear)
        begin
            ballColumn <= pongPkg::ServeColumn;
            ballRow <= pongPkg::RedHitRow;
            towardRed <= 1'b0;
            step <= pongPkg::StepNone;
            redScore <= '0;
            blueScore <= '0;
            pointScored <= 1'b0;
        end
        else
        begin
            pointScored <= 1'b0;
            if (ballTick && result == pongPkg::playing)
            begin
                if (ballRow == hitRow)
                begin
                    if (hit)
                    begin
                        towardRed <= !towardRed;
                        step <= hitStep;
                    end
                    else
                    begin
                        if (towardRed)
                            blueScore <= {blueScore[3:0], 1'b1};
                        else
                            redScore <= {redScore[3:0], 1'b1};
                        pointScored <= 1'b1;
                        // serve from the conceding side toward the scorer
                        ballColumn <= pongPkg::ServeColumn;
                        step <= pongPkg::StepNone;
                        towardRed <= !towardRed;
                    end
                end
                else
                begin
                    ballRow <= towardRed ? ballRow + 3'd1 : ballRow - 3'd1;
                    case (step)
                        pongPkg::StepLeft:
                        begin
                            if (ballColumn == 3'd0)
                            begin
                                step <= pongPkg::StepRight;
                                ballColumn <= ballColumn + 3'd1;
                            end
                            else
                                ballColumn <= ballColumn - 3'd1;
                        end
                        pongPkg::StepRight:
                        begin
                            if (ballColumn == pongPkg::column_t'(pongPkg::BoardSize - 1))
                            begin
                                step <= pongPkg::StepLeft;
                                ballColumn <= ballColumn - 3'd1;
                            end
                            else
                                ballColumn <= ballColumn + 3'd1;
                        end
                        default:
                            ballColumn <= ballColumn;
                    endcase
                end
            end
        end
    end

    // ball never passes a paddle row
    ballInField: assert property (@(posedge CLk) disable iff (Clear)
        ballRow >= pongPkg::BlueHitRow && ballRow <= pongPkg::RedHitRow);

endmodule

`default_nettype wire

// File: rtl/matchControl.sv
`default_nettype none

module matchControl
(
    input  wire                 CLk,
    input  wire                 Clear,
    input  wire                 secondTick,
    input  pongPkg::score_t     redScore,
    input  pongPkg::score_t     blueScore,
    output pongPkg::result_t    result,
    output pongPkg::segments_t  segments
);

    pongPkg::digit_t countdown;

    always_ff @(posedge CLk or posedge Clear)
    begin
        if (Clear)
            countdown <= pongPkg::CountStart;
        else if (secondTick && countdown != 4'd0 && result == pongPkg::playing)
            countdown <= countdown - 4'd1;
    end

    // thermometer codes compare like plain numbers
    always_comb
    begin
        if (redScore == pongPkg::ScoreFull)
            result = pongPkg::redWins;
        else if (blueScore == pongPkg::ScoreFull)
            result = pongPkg::blueWins;
        else if (countdown == 4'd0)
        begin
            if (redScore > blueScore)
                result = pongPkg::redWins;
            else if (blueScore > redScore)
                result = pongPkg::blueWins;
            else
                result = pongPkg::draw;
        end
        else
            result = pongPkg::playing;
    end

    // segment order g..a, inverted for the common-anode digit
    always_comb
    begin
        case (countdown)
            4'd0: segments = ~7'h3f;
            4'd1: segments = ~7'h06;
            4'd2: segments = ~7'h5b;
            4'd3: segments = ~7'h4f;
            4'd4: segments = ~7'h66;
            4'd5: segments = ~7'h6d;
            4'd6: segments = ~7'h7d;
            4'd7: segments = ~7'h07;
            4'd8: segments = ~7'h7f;
            4'd9: segments = ~7'h6f;
            default: segments = 7'h7f;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/displayScanner.sv
`default_nettype none

module displayScanner
(
    input  wire                 CLk,
    input  wire                 Clear,
    input  wire                 scanTick,
    input  pongPkg::column_t    redPaddle,
    input  pongPkg::column_t    bluePaddle,
    input  pongPkg::column_t    ballColumn,
    input  logic [2:0]          ballRow,
    input  pongPkg::result_t    result,
    output pongPkg::ledFrame_t  frame
);

    logic [2:0] slot;
    pongPkg::ledFrame_t nextFrame;

    function automatic pongPkg::rowMask_t rowLow(input logic [2:0] row);
        rowLow = ~(pongPkg::rowMask_t'(1) << row);
    endfunction

    always_comb
    begin
        nextFrame.column = slot;
        nextFrame.red = pongPkg::RowsOff;
        nextFrame.green = pongPkg::RowsOff;
        nextFrame.blue = pongPkg::RowsOff;
        if (result != pongPkg::playing)
        begin
            // end of game fill, a draw lights both colours
            if (result != pongPkg::blueWins)
                nextFrame.red = pongPkg::RowsOn;
            if (result != pongPkg::redWins)
                nextFrame.blue = pongPkg::RowsOn;
        end
        else
        begin
            case (slot)
                3'd0, 3'd1, 3'd2:
                begin
                    nextFrame.column = redPaddle + slot;
                    nextFrame.red = rowLow(pongPkg::RedRow);
                end
                3'd3, 3'd4, 3'd5:
                begin
                    nextFrame.column = bluePaddle + slot - 3'd3;
                    nextFrame.blue = rowLow(pongPkg::BlueRow);
                end
                3'd6:
                begin
                    nextFrame.column = ballColumn;
                    nextFrame.green = rowLow(ballRow);
                end
                default:
                    nextFrame.column = slot;
            endcase
        end
    end

    always_ff @(posedge CLk or posedge Clear)
    begin
        if (Clear)
        begin
            slot <= 3'd0;
            frame <= '{column: 3'd0, red: pongPkg::RowsOff, green: pongPkg::RowsOff,
                       blue: pongPkg::RowsOff};
        end
        else if (scanTick)
        begin
            slot <= slot + 3'd1;
            frame <= nextFrame;
        end
    end

    // only the fill lights more than one row
    singleRowWhilePlaying: assert property (@(posedge CLk) disable iff (Clear)
        result == pongPkg::playing |->
            $onehot0(~frame.red) && $onehot0(~frame.green) && $onehot0(~frame.blue));

endmodule

`default_nettype wire

// File: rtl/slideGame.sv
`default_nettype none

module slideGame
(
    input  wire                 CLk,
    input  wire                 Clear,
    input  pongPkg::buttons_t   redButtons,
    input  pongPkg::buttons_t   blueButtons,
    output pongPkg::ledFrame_t  frame,
    output pongPkg::score_t     redScore,
    output pongPkg::score_t     blueScore,
    output pongPkg::segments_t  segments
);

    logic scanTick;
    logic paddleTick;
    logic ballTick;
    logic secondTick;
    logic pointScored;
    pongPkg::column_t redPaddle;
    pongPkg::column_t bluePaddle;
    pongPkg::column_t ballColumn;
    logic [2:0] ballRow;
    pongPkg::result_t result;

    tickGenerator tickGenerator
    (
        .CLk        (CLk),
        .Clear      (Clear),
        .scanTick   (scanTick),
        .paddleTick (paddleTick),
        .ballTick   (ballTick),
        .secondTick (secondTick)
    );

    paddleControl redPaddleControl
    (
        .CLk         (CLk),
        .Clear       (Clear),
        .paddleTick  (paddleTick),
        .pointScored (pointScored),
        .buttons     (redButtons),
        .position    (redPaddle)
    );

    paddleControl bluePaddleControl
    (
        .CLk         (CLk),
        .Clear       (Clear),
        .paddleTick  (paddleTick),
        .pointScored (pointScored),
        .buttons     (blueButtons),
        .position    (bluePaddle)
    );

    ballEngine ballEngine
    (
        .CLk         (CLk),
        .Clear       (Clear),
        .ballTick    (ballTick),
        .redPaddle   (redPaddle),
        .bluePaddle  (bluePaddle),
        .result      (result),
        .ballColumn  (ballColumn),
        .ballRow     (ballRow),
        .redScore    (redScore),
        .blueScore   (blueScore),
        .pointScored (pointScored)
    );

    matchControl matchControl
    (
        .CLk        (CLk),
        .Clear      (Clear),
        .secondTick (secondTick),
        .redScore   (redScore),
        .blueScore  (blueScore),
        .result     (result),
        .segments   (segments)
    );

    displayScanner displayScanner
    (
        .CLk        (CLk),
        .Clear      (Clear),
        .scanTick   (scanTick),
        .redPaddle  (redPaddle),
        .bluePaddle (bluePaddle),
        .ballColumn (ballColumn),
        .ballRow    (ballRow),
        .result     (result),
        .frame      (frame)
    );

endmodule

`default_nettype wire

// File: test/slideGameTb.sv
`default_nettype none

module slideGameTb;

    logic CLk;
    logic Clear;
    pongPkg::buttons_t redButtons;
    pongPkg::buttons_t blueButtons;
    pongPkg::ledFrame_t frame;
    pongPkg::score_t redScore;
    pongPkg::score_t blueScore;
    pongPkg::segments_t segments;

    int errorCount;
    int checkCount;
    logic [31:0] lfsrState;

    slideGame i_slideGame
    (
        .CLk         (CLk),
        .Clear       (Clear),
        .redButtons  (redButtons),
        .blueButtons (blueButtons),
        .frame       (frame),
        .redScore    (redScore),
        .blueScore   (blueScore),
        .segments    (segments)
    );

    initial
    begin
        CLk = 1'b0;
        forever #2 CLk = ~CLk;
    end

    // taps 32, 22, 2, 1, new bit enters at the bottom
    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        nextLfsr = {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic randomBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            lfsrState = nextLfsr(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    // standard shapes as g..a, the digit itself is active low
    function automatic pongPkg::segments_t digitSegments(input int digit);
        logic [6:0] shape;
        case (digit)
            0: shape = 7'b0111111;
            1: shape = 7'b0000110;
            2: shape = 7'b1011011;
            3: shape = 7'b1001111;
            4: shape = 7'b1100110;
            5: shape = 7'b1101101;
            6: shape = 7'b1111101;
            7: shape = 7'b0000111;
            8: shape = 7'b1111111;
            9: shape = 7'b1101111;
            default: shape = 7'b0000000;
        endcase
        digitSegments = ~shape;
    endfunction

    task automatic checkScore(input string testName, input pongPkg::score_t expected,
                              input pongPkg::score_t actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("ERROR %s: score expected %b, actual %b", testName, expected, actual);
        end
    endtask

    task automatic checkSegments(input string testName, input pongPkg::segments_t expected,
                                 input pongPkg::segments_t actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("ERROR %s: segments expected %b, actual %b", testName, expected, actual);
        end
    endtask

    task automatic checkColumn(input string testName, input pongPkg::column_t expected,
                               input pongPkg::column_t actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("ERROR %s: column expected %0d, actual %0d", testName, expected, actual);
        end
    endtask

    task automatic checkRows(input string testName, input pongPkg::rowMask_t expected,
                             input pongPkg::rowMask_t actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("ERROR %s: rows expected %b, actual %b", testName, expected, actual);
        end
    endtask

    task automatic reportFailure(input string testName, input string what);
        errorCount++;
        $display("%s: %s", testName, what);
    endtask

    task automatic applyReset;
        @(posedge CLk);
        Clear <= 1'b1;
        redButtons <= '0;
        blueButtons <= '0;
        repeat (5) @(posedge CLk);
        Clear <= 1'b0;
    endtask

    task automatic pressButtons(input logic redLeft, input logic redRight,
                                input logic blueLeft, input logic blueRight);
        @(posedge CLk);
        redButtons.left <= redLeft;
        redButtons.right <= redRight;
        blueButtons.left <= blueLeft;
        blueButtons.right <= blueRight;
    endtask

    task automatic waitScoreChange(input string testName, input bit blueSide,
                                   input pongPkg::score_t previous, input int limit,
                                   output bit changed);
        pongPkg::score_t current;
        changed = 1'b0;
        for (int cycle = 0; cycle < limit && !changed; cycle++)
        begin
            @(negedge CLk);
            current = blueSide ? blueScore : redScore;
            changed = current != previous;
        end
        if (!changed)
            reportFailure(testName, "the score did not change before the timeout");
    endtask

    task automatic waitSegmentsChange(input string testName, input pongPkg::segments_t previous,
                                      input int limit, output bit changed);
        changed = 1'b0;
        for (int cycle = 0; cycle < limit && !changed; cycle++)
        begin
            @(negedge CLk);
            changed = segments != previous;
        end
        if (!changed)
            reportFailure(testName, "the countdown digit did not change before the timeout");
    endtask

    // one whole run of three paddle slots, entered from a non-paddle slot
    task automatic capturePaddle(input bit blueSide, output pongPkg::column_t [2:0] cells,
                                 output bit found);
        pongPkg::ledFrame_t last;
        pongPkg::rowMask_t mask;
        logic [1:0] count;
        bit inRun;
        bit paddleNow;
        bit lastPaddle;
        found = 1'b0;
        inRun = 1'b0;
        count = 2'd0;
        cells = '0;
        last = frame;
        lastPaddle = (blueSide ? last.blue : last.red) != pongPkg::RowsOff;
        for (int cycle = 0; cycle < 16 * pongPkg::ScanPeriod && !found; cycle++)
        begin
            @(negedge CLk);
            if (frame != last)
            begin
                mask = blueSide ? frame.blue : frame.red;
                paddleNow = mask != pongPkg::RowsOff;
                if (paddleNow && !lastPaddle)
                begin
                    inRun = 1'b1;
                    count = 2'd0;
                end
                if (paddleNow && inRun)
                begin
                    cells[count] = frame.column;
                    count = count + 2'd1;
                    found = count == 2'd3;
                end
                if (!paddleNow)
                    inRun = 1'b0;
                lastPaddle = paddleNow;
                last = frame;
            end
        end
    endtask

    task automatic checkPlayingFrames(input string testName);
        int lowBits;
        repeat (2 * pongPkg::BoardSize * pongPkg::ScanPeriod)
        begin
            @(negedge CLk);
            lowBits = $countones(~frame.red) + $countones(~frame.green)
                    + $countones(~frame.blue);
            if (lowBits > 1)
                reportFailure(testName, "a frame lit more than one row while playing");
            if (frame.red != pongPkg::RowsOff)
                checkRows(testName, pongPkg::RowsOff ^ (8'd1 << pongPkg::RedRow), frame.red);
            if (frame.blue != pongPkg::RowsOff)
                checkRows(testName, pongPkg::RowsOff ^ (8'd1 << pongPkg::BlueRow), frame.blue);
        end
    endtask

    task automatic checkFill(input string testName, input bit redLit, input bit blueLit);
        logic [7:0] columnsSeen;
        columnsSeen = '0;
        // let the scanner pick up the result
        repeat (2 * pongPkg::ScanPeriod) @(negedge CLk);
        repeat (pongPkg::BoardSize * pongPkg::ScanPeriod)
        begin
            @(negedge CLk);
            columnsSeen[frame.column] = 1'b1;
            checkRows(testName, redLit ? pongPkg::RowsOn : pongPkg::RowsOff, frame.red);
            checkRows(testName, pongPkg::RowsOff, frame.green);
            checkRows(testName, blueLit ? pongPkg::RowsOn : pongPkg::RowsOff, frame.blue);
        end
        if (columnsSeen != 8'hff)
            reportFailure(testName, "the colour fill did not sweep every column");
    endtask

    task automatic testResetState;
        string name;
        name = "reset state";
        applyReset();
        @(negedge CLk);
        checkScore(name, '0, redScore);
        checkScore(name, '0, blueScore);
        checkSegments(name, digitSegments(9), segments);
        checkColumn(name, 3'd0, frame.column);
        checkRows(name, pongPkg::RowsOff, frame.red);
        checkRows(name, pongPkg::RowsOff, frame.green);
        checkRows(name, pongPkg::RowsOff, frame.blue);
        checkPlayingFrames(name);
    endtask

    task automatic testPaddleClamp;
        string name;
        int holdPeriods;
        pongPkg::column_t [2:0] cells;
        bit found;
        name = "paddle clamp";
        randomBits(3, holdPeriods);
        holdPeriods = holdPeriods + 11;
        applyReset();
        pressButtons(1'b0, 1'b1, 1'b0, 1'b0);
        repeat (holdPeriods * pongPkg::PaddlePeriod) @(posedge CLk);
        capturePaddle(1'b0, cells, found);
        if (!found)
            reportFailure(name, "no complete red paddle scan was seen");
        else
        begin
            checkColumn(name, pongPkg::PaddleMax, cells[0]);
            checkColumn(name, pongPkg::PaddleMax + 3'd1, cells[1]);
            checkColumn(name, pongPkg::PaddleMax + 3'd2, cells[2]);
        end
        // blue checked before the first ball reaches its hit row
        applyReset();
        pressButtons(1'b0, 1'b0, 1'b1, 1'b0);
        repeat (6 * pongPkg::PaddlePeriod) @(posedge CLk);
        capturePaddle(1'b1, cells, found);
        if (!found)
            reportFailure(name, "no complete blue paddle scan was seen");
        else
        begin
            checkColumn(name, 3'd0, cells[0]);
            checkColumn(name, 3'd1, cells[1]);
            checkColumn(name, 3'd2, cells[2]);
        end
    endtask

    task automatic testOutrightWin(input bit blueWinner);
        string name;
        pongPkg::score_t expected;
        pongPkg::score_t previous;
        pongPkg::segments_t heldSegments;
        bit changed;
        name = blueWinner ? "blue win" : "red win";
        applyReset();
        // loser parks at column 0, away from the serve column
        pressButtons(blueWinner, 1'b0, !blueWinner, 1'b0);
        expected = '0;
        for (int point = 0; point < 5; point++)
        begin
            previous = expected;
            expected = {expected[3:0], 1'b1};
            waitScoreChange(name, blueWinner, previous, 24 * pongPkg::BallPeriod, changed);
            if (!changed)
                return;
            checkScore(name, expected, blueWinner ? blueScore : redScore);
            checkScore(name, '0, blueWinner ? redScore : blueScore);
        end
        checkFill(name, !blueWinner, blueWinner);
        heldSegments = segments;
        repeat (2 * pongPkg::SecondPeriod) @(negedge CLk);
        checkSegments(name, heldSegments, segments);
    endtask

    task automatic testDraw;
        string name;
        pongPkg::segments_t previous;
        bit changed;
        name = "draw on timeout";
        applyReset();
        // a full rally should stay on the serve column
        repeat (16 * pongPkg::BallPeriod)
        begin
            @(negedge CLk);
            if (frame.green != pongPkg::RowsOff)
                checkColumn(name, pongPkg::ServeColumn, frame.column);
        end
        for (int digit = 8; digit >= 0; digit--)
        begin
            previous = segments;
            waitSegmentsChange(name, previous, pongPkg::SecondPeriod + 64, changed);
            if (!changed)
                return;
            checkSegments(name, digitSegments(digit), segments);
            checkScore(name, '0, redScore);
            checkScore(name, '0, blueScore);
        end
        checkFill(name, 1'b1, 1'b1);
    endtask

    task automatic testLeadAtTimeout;
        string name;
        bit changed;
        name = "lead at timeout";
        applyReset();
        pressButtons(1'b0, 1'b0, 1'b1, 1'b0);
        waitScoreChange(name, 1'b0, '0, 24 * pongPkg::BallPeriod, changed);
        if (!changed)
            return;
        pressButtons(1'b0, 1'b0, 1'b0, 1'b0);
        checkScore(name, 5'b00001, redScore);
        for (int second = 0; second < 9 && segments != digitSegments(0); second++)
        begin
            waitSegmentsChange(name, segments, pongPkg::SecondPeriod + 64, changed);
            if (!changed)
                return;
        end
        checkScore(name, 5'b00001, redScore);
        checkScore(name, '0, blueScore);
        checkFill(name, 1'b1, 1'b0);
    endtask

    initial
    begin
        Clear = 1'b1;
        redButtons = '0;
        blueButtons = '0;
        errorCount = 0;
        checkCount = 0;
        lfsrState = 32'hdb81764b;
        testResetState();
        testPaddleClamp();
        testOutrightWin(1'b0);
        testOutrightWin(1'b1);
        testDraw();
        testLeadAtTimeout();
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
rtl/pongPkg.sv
rtl/tickGenerator.sv
rtl/paddleControl.sv
rtl/ballEngine.sv
rtl/matchControl.sv
rtl/displayScanner.sv
rtl/slideGame.sv
test/slideGameTb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run the testbench and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module slideGameTb -o slideGameSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/slideGameSim > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
exit 1
